// ==== hdl/raster_pkg.sv ====
`default_nettype none

package raster_pkg;

    // Vertex coordinates are signed fixed point with this many fraction bits
    localparam int FRAC_BITS = 4;

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_SETUP,
        WALK_WALK,
        WALK_DONE
    } walk_state_e;

    typedef enum logic {
        CLR_IDLE,
        CLR_SWEEP
    } clear_state_e;

    // Source that owns the framebuffer write port
    typedef enum logic {
        FB_OP_PIXEL,
        FB_OP_CLEAR
    } fb_op_e;

endpackage

`default_nettype wire

// ==== hdl/bbox_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bbox_walker import raster_pkg::*; #(
    parameter int WORD_WIDTH = 32,
    parameter int WIDTH      = 64,
    parameter int HEIGHT     = 48,
    parameter int CREDITS    = 4,
    localparam int SC_WIDTH  = $clog2(WIDTH > HEIGHT ? WIDTH : HEIGHT)
) (
    input  wire                         clk_i,
    input  wire                         nrst_i,
    input  wire                         start_i,
    input  wire signed [WORD_WIDTH-1:0] v0x_i,
    input  wire signed [WORD_WIDTH-1:0] v0y_i,
    input  wire signed [WORD_WIDTH-1:0] v1x_i,
    input  wire signed [WORD_WIDTH-1:0] v1y_i,
    input  wire signed [WORD_WIDTH-1:0] v2x_i,
    input  wire signed [WORD_WIDTH-1:0] v2y_i,
    output logic                        pos_valid_o,
    output logic [SC_WIDTH-1:0]         pos_x_o,
    output logic [SC_WIDTH-1:0]         pos_y_o,
    output logic                        pos_last_o,
    input  wire                         pos_credit_i,
    output logic                        discard_o,
    output logic                        busy_o
);
    localparam int CNT_W  = $clog2(CREDITS + 1);
    localparam int AREA_W = 2 * WORD_WIDTH + 3;

    walk_state_e                  state;
    logic signed [WORD_WIDTH-1:0] lo_x, hi_x, lo_y, hi_y;   // Box in whole pixels
    logic signed [AREA_W-1:0]     area;
    logic                         off_screen;
    logic [SC_WIDTH-1:0]          cx0, cx1, cy0, cy1;
    logic [SC_WIDTH-1:0]          bx0, bx1, by1;
    logic [SC_WIDTH-1:0]          px, py;
    logic [CNT_W-1:0]             credits;
    logic                         fire, last;

    function automatic logic signed [WORD_WIDTH-1:0] min3(
        input logic signed [WORD_WIDTH-1:0] a, b, c);
        logic signed [WORD_WIDTH-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [WORD_WIDTH-1:0] max3(
        input logic signed [WORD_WIDTH-1:0] a, b, c);
        logic signed [WORD_WIDTH-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign lo_x = min3(v0x_i, v1x_i, v2x_i) >>> FRAC_BITS;
    assign hi_x = max3(v0x_i, v1x_i, v2x_i) >>> FRAC_BITS;
    assign lo_y = min3(v0y_i, v1y_i, v2y_i) >>> FRAC_BITS;
    assign hi_y = max3(v0y_i, v1y_i, v2y_i) >>> FRAC_BITS;

    // Doubled signed area, positive for counter-clockwise winding
    assign area = (v1x_i - v0x_i) * (v2y_i - v0y_i) - (v1y_i - v0y_i) * (v2x_i - v0x_i);

    assign off_screen = hi_x < 0 || hi_y < 0 || lo_x >= WIDTH || lo_y >= HEIGHT;

    // Clip to the screen
    assign cx0 = (lo_x < 0) ? '0 : lo_x[SC_WIDTH-1:0];
    assign cy0 = (lo_y < 0) ? '0 : lo_y[SC_WIDTH-1:0];
    assign cx1 = (hi_x >= WIDTH) ? SC_WIDTH'(WIDTH - 1) : hi_x[SC_WIDTH-1:0];
    assign cy1 = (hi_y >= HEIGHT) ? SC_WIDTH'(HEIGHT - 1) : hi_y[SC_WIDTH-1:0];

    assign fire = state == WALK_WALK && credits != '0;
    assign last = px == bx1 && py == by1;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state     <= WALK_IDLE;
            credits   <= CNT_W'(CREDITS);
            discard_o <= 1'b0;
        end else begin
            discard_o <= 1'b0;
            credits   <= credits + CNT_W'(pos_credit_i) - CNT_W'(fire);
            case (state)
                WALK_IDLE: begin
                    if (start_i) state <= WALK_SETUP;
                end
                WALK_SETUP: begin
                    if (area <= 0 || off_screen) begin
                        discard_o <= 1'b1;
                        state     <= WALK_IDLE;
                    end else begin
                        state <= WALK_WALK;
                    end
                end
                WALK_WALK: begin
                    if (fire && last) state <= WALK_DONE;
                end
                default: state <= WALK_IDLE;
            endcase
        end
    end

    // Row-order scan of the clipped box
    always_ff @(posedge clk_i) begin
        if (state == WALK_SETUP) begin
            bx0 <= cx0;
            bx1 <= cx1;
            by1 <= cy1;
            px  <= cx0;
            py  <= cy0;
        end else if (fire) begin
            if (px == bx1) begin
                px <= bx0;
                py <= py + 1'b1;
            end else begin
                px <= px + 1'b1;
            end
        end
    end

    assign pos_valid_o = fire;
    assign pos_x_o     = px;
    assign pos_y_o     = py;
    assign pos_last_o  = last;
    assign busy_o      = state != WALK_IDLE;

endmodule

`default_nettype wire

// ==== hdl/edge_eval.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_eval import raster_pkg::*; #(
    parameter int WORD_WIDTH = 32,
    parameter int WIDTH      = 64,
    parameter int HEIGHT     = 48,
    parameter int CREDITS    = 4,
    localparam int SC_WIDTH  = $clog2(WIDTH > HEIGHT ? WIDTH : HEIGHT)
) (
    input  wire                         clk_i,
    input  wire                         nrst_i,
    input  wire signed [WORD_WIDTH-1:0] v0x_i,
    input  wire signed [WORD_WIDTH-1:0] v0y_i,
    input  wire signed [WORD_WIDTH-1:0] v1x_i,
    input  wire signed [WORD_WIDTH-1:0] v1y_i,
    input  wire signed [WORD_WIDTH-1:0] v2x_i,
    input  wire signed [WORD_WIDTH-1:0] v2y_i,
    input  wire                         pos_valid_i,
    input  wire [SC_WIDTH-1:0]          pos_x_i,
    input  wire [SC_WIDTH-1:0]          pos_y_i,
    input  wire                         pos_last_i,
    output logic                        pos_credit_o,
    output logic                        pix_valid_o,
    output logic [SC_WIDTH-1:0]         pix_x_o,
    output logic [SC_WIDTH-1:0]         pix_y_o,
    output logic                        pix_last_o,
    output logic                        pix_keep_o,
    input  wire                         pix_credit_i
);
    localparam int CNT_W  = $clog2(CREDITS + 1);
    localparam int PTR_W  = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int EDGE_W = 2 * WORD_WIDTH + 3;

    logic [SC_WIDTH-1:0]          q_x [CREDITS];
    logic [SC_WIDTH-1:0]          q_y [CREDITS];
    logic                         q_last [CREDITS];
    logic [PTR_W-1:0]             wr_ptr, rd_ptr;
    logic [CNT_W-1:0]             q_count, credits;
    logic                         deq, drop;
    logic signed [WORD_WIDTH-1:0] sx, sy;
    logic                         s1_valid, s1_last;
    logic [SC_WIDTH-1:0]          s1_x, s1_y;
    logic signed [EDGE_W-1:0]     s1_e0, s1_e1, s1_e2;
    logic                         s2_valid;

    function automatic logic signed [EDGE_W-1:0] edge_fn(
        input logic signed [WORD_WIDTH-1:0] ax, ay, bx, by, px, py);
        logic signed [EDGE_W-1:0] dx, dy, qx, qy;
        dx = bx - ax;
        dy = by - ay;
        qx = px - ax;
        qy = py - ay;
        return dx * qy - dy * qx;
    endfunction

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    // A downstream credit is reserved at dequeue and handed back if the pixel is dropped
    assign deq  = q_count != '0 && credits != '0;
    assign drop = s2_valid && !pix_keep_o && !pix_last_o;

    // Sample point in vertex fixed point
    assign sx = {{(WORD_WIDTH - SC_WIDTH - FRAC_BITS){1'b0}}, q_x[rd_ptr], {FRAC_BITS{1'b0}}};
    assign sy = {{(WORD_WIDTH - SC_WIDTH - FRAC_BITS){1'b0}}, q_y[rd_ptr], {FRAC_BITS{1'b0}}};

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            q_count  <= '0;
            credits  <= CNT_W'(CREDITS);
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (pos_valid_i) wr_ptr <= next_ptr(wr_ptr);
            if (deq) rd_ptr <= next_ptr(rd_ptr);
            q_count  <= q_count + CNT_W'(pos_valid_i) - CNT_W'(deq);
            credits  <= credits - CNT_W'(deq) + CNT_W'(pix_credit_i) + CNT_W'(drop);
            s1_valid <= deq;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pos_valid_i) begin
            q_x[wr_ptr]    <= pos_x_i;
            q_y[wr_ptr]    <= pos_y_i;
            q_last[wr_ptr] <= pos_last_i;
        end
        s1_x    <= q_x[rd_ptr];
        s1_y    <= q_y[rd_ptr];
        s1_last <= q_last[rd_ptr];
        s1_e0   <= edge_fn(v0x_i, v0y_i, v1x_i, v1y_i, sx, sy);
        s1_e1   <= edge_fn(v1x_i, v1y_i, v2x_i, v2y_i, sx, sy);
        s1_e2   <= edge_fn(v2x_i, v2y_i, v0x_i, v0y_i, sx, sy);
        pix_x_o    <= s1_x;
        pix_y_o    <= s1_y;
        pix_last_o <= s1_last;
        pix_keep_o <= s1_e0 >= 0 && s1_e1 >= 0 && s1_e2 >= 0;
    end

    assign pos_credit_o = deq;
    assign pix_valid_o  = s2_valid && (pix_keep_o || pix_last_o);   // Last always goes on

endmodule

`default_nettype wire

// ==== hdl/fb_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_writer import raster_pkg::*; #(
    parameter int WIDTH       = 64,
    parameter int HEIGHT      = 48,
    parameter int CREDITS     = 4,
    localparam int SC_WIDTH   = $clog2(WIDTH > HEIGHT ? WIDTH : HEIGHT),
    localparam int ADDR_WIDTH = $clog2(WIDTH * HEIGHT)
) (
    input  wire                   clk_i,
    input  wire                   nrst_i,
    input  wire [7:0]             color_i,
    input  wire                   pix_valid_i,
    input  wire [SC_WIDTH-1:0]    pix_x_i,
    input  wire [SC_WIDTH-1:0]    pix_y_i,
    input  wire                   pix_last_i,
    input  wire                   pix_keep_i,
    output logic                  pix_credit_o,
    output logic                  wr_req_o,
    output logic [ADDR_WIDTH-1:0] wr_addr_o,
    output logic [7:0]            wr_data_o,
    input  wire                   gnt_valid_i,
    input  wire fb_op_e           gnt_op_i,
    output logic                  job_end_o
);
    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

    logic [SC_WIDTH-1:0] q_x [CREDITS];
    logic [SC_WIDTH-1:0] q_y [CREDITS];
    logic                q_last [CREDITS];
    logic                q_keep [CREDITS];
    logic [PTR_W-1:0]    wr_ptr, rd_ptr;
    logic [CNT_W-1:0]    q_count;
    logic                has_item, retire;

    assign has_item = q_count != '0;
    assign wr_req_o = has_item && q_keep[rd_ptr];
    // Marker items leave without a write
    assign retire   = has_item && (!q_keep[rd_ptr] || (gnt_valid_i && gnt_op_i == FB_OP_PIXEL));

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            job_end_o <= 1'b0;
        end else begin
            if (pix_valid_i) wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (retire) rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            q_count   <= q_count + CNT_W'(pix_valid_i) - CNT_W'(retire);
            job_end_o <= retire && q_last[rd_ptr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (pix_valid_i) begin
            q_x[wr_ptr]    <= pix_x_i;
            q_y[wr_ptr]    <= pix_y_i;
            q_last[wr_ptr] <= pix_last_i;
            q_keep[wr_ptr] <= pix_keep_i;
        end
    end

    assign wr_addr_o    = ADDR_WIDTH'(q_y[rd_ptr] * WIDTH + q_x[rd_ptr]);
    assign wr_data_o    = color_i;
    assign pix_credit_o = retire;

endmodule

`default_nettype wire

// ==== hdl/fb_clear.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_clear import raster_pkg::*; #(
    parameter int WIDTH       = 64,
    parameter int HEIGHT      = 48,
    localparam int ADDR_WIDTH = $clog2(WIDTH * HEIGHT)
) (
    input  wire                   clk_i,
    input  wire                   nrst_i,
    input  wire                   clear_i,
    input  wire [7:0]             bg_color_i,
    output logic                  clr_req_o,
    output logic [ADDR_WIDTH-1:0] clr_addr_o,
    output logic [7:0]            clr_data_o,
    input  wire                   gnt_valid_i,
    input  wire fb_op_e           gnt_op_i,
    output logic                  clear_done_o
);
    clear_state_e          state;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            color_q;
    logic                  grant;

    assign grant = gnt_valid_i && gnt_op_i == FB_OP_CLEAR;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state        <= CLR_IDLE;
            addr         <= '0;
            clear_done_o <= 1'b0;
        end else begin
            clear_done_o <= 1'b0;
            case (state)
                CLR_IDLE: begin
                    if (clear_i) begin
                        state <= CLR_SWEEP;
                        addr  <= '0;
                    end
                end
                default: begin
                    if (grant) begin
                        if (addr == ADDR_WIDTH'(WIDTH * HEIGHT - 1)) begin
                            state        <= CLR_IDLE;
                            clear_done_o <= 1'b1;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == CLR_IDLE && clear_i) color_q <= bg_color_i;
    end

    assign clr_req_o  = state == CLR_SWEEP;
    assign clr_addr_o = addr;
    assign clr_data_o = color_q;

endmodule

`default_nettype wire

// ==== hdl/fb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter import raster_pkg::*; #(
    parameter int WIDTH       = 64,
    parameter int HEIGHT      = 48,
    localparam int ADDR_WIDTH = $clog2(WIDTH * HEIGHT)
) (
    input  wire                   clk_i,
    input  wire                   nrst_i,
    input  wire                   wr_req_i,
    input  wire [ADDR_WIDTH-1:0]  wr_addr_i,
    input  wire [7:0]             wr_data_i,
    input  wire                   clr_req_i,
    input  wire [ADDR_WIDTH-1:0]  clr_addr_i,
    input  wire [7:0]             clr_data_i,
    output logic                  gnt_valid_o,
    output fb_op_e                gnt_op_o,
    output logic                  fb_we_o,
    output logic [ADDR_WIDTH-1:0] fb_addr_o,
    output logic [7:0]            fb_wdata_o
);
    fb_op_e last_q;
    fb_op_e winner;

    always_comb begin
        if (wr_req_i && clr_req_i) begin
            winner = (last_q == FB_OP_PIXEL) ? FB_OP_CLEAR : FB_OP_PIXEL;   // Alternate
        end else if (clr_req_i) begin
            winner = FB_OP_CLEAR;
        end else begin
            winner = FB_OP_PIXEL;
        end
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            last_q <= FB_OP_CLEAR;
        end else if (gnt_valid_o) begin
            last_q <= winner;
        end
    end

    assign gnt_valid_o = wr_req_i || clr_req_i;
    assign gnt_op_o    = winner;
    assign fb_we_o     = gnt_valid_o;
    assign fb_addr_o   = (winner == FB_OP_CLEAR) ? clr_addr_i : wr_addr_i;
    assign fb_wdata_o  = (winner == FB_OP_CLEAR) ? clr_data_i : wr_data_i;

endmodule

`default_nettype wire

// ==== hdl/raster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_top import raster_pkg::*; #(
    parameter int WORD_WIDTH  = 32,
    parameter int WIDTH       = 64,
    parameter int HEIGHT      = 48,
    parameter int CREDITS     = 4,
    localparam int ADDR_WIDTH = $clog2(WIDTH * HEIGHT)
) (
    input  wire                         clk_i,
    input  wire                         nrst_i,
    input  wire                         start_i,
    input  wire [7:0]                   color_i,
    input  wire signed [WORD_WIDTH-1:0] v0x_i,
    input  wire signed [WORD_WIDTH-1:0] v0y_i,
    input  wire signed [WORD_WIDTH-1:0] v1x_i,
    input  wire signed [WORD_WIDTH-1:0] v1y_i,
    input  wire signed [WORD_WIDTH-1:0] v2x_i,
    input  wire signed [WORD_WIDTH-1:0] v2y_i,
    input  wire                         clear_i,
    input  wire [7:0]                   bg_color_i,
    output logic                        busy_o,
    output logic                        done_o,
    output logic                        clear_done_o,
    output logic                        fb_we_o,
    output logic [ADDR_WIDTH-1:0]       fb_addr_o,
    output logic [7:0]                  fb_wdata_o
);
    localparam int SC_WIDTH = $clog2(WIDTH > HEIGHT ? WIDTH : HEIGHT);

    logic                  walk_start, walk_busy, discard, draw_open;
    logic                  pos_valid, pos_last, pos_credit;
    logic [SC_WIDTH-1:0]   pos_x, pos_y;
    logic                  pix_valid, pix_last, pix_keep, pix_credit;
    logic [SC_WIDTH-1:0]   pix_x, pix_y;
    logic                  wr_req, clr_req, gnt_valid, job_end;
    logic [ADDR_WIDTH-1:0] wr_addr, clr_addr;
    logic [7:0]            wr_data, clr_data;
    fb_op_e                gnt_op;

    // A draw stays open from the accepted start until the writer retires the last item
    assign walk_start = start_i && !busy_o;
    assign done_o     = job_end || discard;
    assign busy_o     = walk_busy || (draw_open && !done_o);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            draw_open <= 1'b0;
        end else if (walk_start) begin
            draw_open <= 1'b1;
        end else if (done_o) begin
            draw_open <= 1'b0;
        end
    end

    bbox_walker #(.WORD_WIDTH(WORD_WIDTH), .WIDTH(WIDTH), .HEIGHT(HEIGHT), .CREDITS(CREDITS))
    i_walker (
        .clk_i(clk_i), .nrst_i(nrst_i), .start_i(walk_start),
        .v0x_i(v0x_i), .v0y_i(v0y_i), .v1x_i(v1x_i),
        .v1y_i(v1y_i), .v2x_i(v2x_i), .v2y_i(v2y_i),
        .pos_valid_o(pos_valid), .pos_x_o(pos_x), .pos_y_o(pos_y),
        .pos_last_o(pos_last), .pos_credit_i(pos_credit),
        .discard_o(discard), .busy_o(walk_busy)
    );

    edge_eval #(.WORD_WIDTH(WORD_WIDTH), .WIDTH(WIDTH), .HEIGHT(HEIGHT), .CREDITS(CREDITS))
    i_edge (
        .clk_i(clk_i), .nrst_i(nrst_i),
        .v0x_i(v0x_i), .v0y_i(v0y_i), .v1x_i(v1x_i),
        .v1y_i(v1y_i), .v2x_i(v2x_i), .v2y_i(v2y_i),
        .pos_valid_i(pos_valid), .pos_x_i(pos_x), .pos_y_i(pos_y),
        .pos_last_i(pos_last), .pos_credit_o(pos_credit),
        .pix_valid_o(pix_valid), .pix_x_o(pix_x), .pix_y_o(pix_y),
        .pix_last_o(pix_last), .pix_keep_o(pix_keep), .pix_credit_i(pix_credit)
    );

    fb_writer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT), .CREDITS(CREDITS)) i_writer (
        .clk_i(clk_i), .nrst_i(nrst_i), .color_i(color_i),
        .pix_valid_i(pix_valid), .pix_x_i(pix_x), .pix_y_i(pix_y),
        .pix_last_i(pix_last), .pix_keep_i(pix_keep), .pix_credit_o(pix_credit),
        .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .gnt_valid_i(gnt_valid), .gnt_op_i(gnt_op), .job_end_o(job_end)
    );

    fb_clear #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_clear (
        .clk_i(clk_i), .nrst_i(nrst_i), .clear_i(clear_i), .bg_color_i(bg_color_i),
        .clr_req_o(clr_req), .clr_addr_o(clr_addr), .clr_data_o(clr_data),
        .gnt_valid_i(gnt_valid), .gnt_op_i(gnt_op), .clear_done_o(clear_done_o)
    );

    fb_arbiter #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) i_arbiter (
        .clk_i(clk_i), .nrst_i(nrst_i),
        .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .clr_req_i(clr_req), .clr_addr_i(clr_addr), .clr_data_i(clr_data),
        .gnt_valid_o(gnt_valid), .gnt_op_o(gnt_op),
        .fb_we_o(fb_we_o), .fb_addr_o(fb_addr_o), .fb_wdata_o(fb_wdata_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_raster.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_raster import raster_pkg::*; ();
    localparam int WORD_WIDTH     = 32;
    localparam int WIDTH          = 16;
    localparam int HEIGHT         = 12;
    localparam int NPIX           = WIDTH * HEIGHT;
    localparam int ADDR_WIDTH     = $clog2(NPIX);
    localparam int NUM_JOBS       = 16;   // 2 clears and 14 draws, each at most NPIX pixels
    localparam int TIMEOUT_CYCLES = 20 * NUM_JOBS * NPIX + 2000;
    localparam int DRIVE_DLY      = 10;

    logic                         clk_i, nrst_i, start_i, clear_i;
    logic [7:0]                   color_i, bg_color_i;
    logic signed [WORD_WIDTH-1:0] v0x_i, v0y_i, v1x_i, v1y_i, v2x_i, v2y_i;
    logic                         busy_o, done_o, clear_done_o, fb_we_o;
    logic [ADDR_WIDTH-1:0]        fb_addr_o;
    logic [7:0]                   fb_wdata_o;

    // Framebuffer model
    logic [7:0] fb_mem [NPIX];
    logic [7:0] fb_before [NPIX];
    int         wr_count [NPIX];
    bit         exp_keep [NPIX];
    longint     vx [3];
    longint     vy [3];
    int         cycles = 0;
    int         done_count = 0;
    int         total_writes = 0;
    int         clr_next = 0;
    int         last_clr_cycle = 0;
    bit         clear_active = 1'b0;

    raster_top #(.WORD_WIDTH(WORD_WIDTH), .WIDTH(WIDTH), .HEIGHT(HEIGHT), .CREDITS(4)) i_dut (
        .clk_i(clk_i), .nrst_i(nrst_i), .start_i(start_i), .color_i(color_i),
        .v0x_i(v0x_i), .v0y_i(v0y_i), .v1x_i(v1x_i),
        .v1y_i(v1y_i), .v2x_i(v2x_i), .v2y_i(v2y_i),
        .clear_i(clear_i), .bg_color_i(bg_color_i),
        .busy_o(busy_o), .done_o(done_o), .clear_done_o(clear_done_o),
        .fb_we_o(fb_we_o), .fb_addr_o(fb_addr_o), .fb_wdata_o(fb_wdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic flag_mismatch(input string msg);
        abort_run($sformatf("FAILED at time %0t: %s", $time, msg));
    endtask

    // Memory writes, clear sweep order and the cycle limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
        if (done_o) done_count <= done_count + 1;
        if (fb_we_o) begin
            fb_mem[fb_addr_o]   <= fb_wdata_o;
            wr_count[fb_addr_o] <= wr_count[fb_addr_o] + 1;
            total_writes        <= total_writes + 1;
        end
        if (clear_done_o) begin
            assert (clear_active && clr_next == NPIX && last_clr_cycle == cycles - 1)
                else flag_mismatch($sformatf("clear_done_o after %0d clear writes", clr_next));
            clear_active <= 1'b0;
        end else if (clear_active) begin
            assert (fb_we_o) else flag_mismatch("write port idle during a clear");
            if (fb_we_o && fb_wdata_o == bg_color_i) begin
                assert (fb_addr_o == clr_next)
                    else flag_mismatch($sformatf("clear wrote %0d, expected %0d",
                                                 fb_addr_o, clr_next));
                clr_next       <= clr_next + 1;
                last_clr_cycle <= cycles;
            end
        end
        if (clear_i) begin   // Sweep starts with the accepted clear
            clear_active <= 1'b1;
            clr_next     <= 0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!nrst_i) fb_we_o |-> fb_addr_o < NPIX)
        else flag_mismatch("write address outside the framebuffer");
    assert property (@(posedge clk_i) disable iff (!nrst_i) done_o |=> !done_o)
        else flag_mismatch("done_o held for more than one cycle");
    assert property (@(posedge clk_i) disable iff (!nrst_i) clear_done_o |=> !clear_done_o)
        else flag_mismatch("clear_done_o held for more than one cycle");

    function automatic longint lo3(input longint a, b, c);
        longint m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic longint hi3(input longint a, b, c);
        longint m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Edge from vertex i to vertex j seen from point p; for i = 0, j = 1 and p = v2 it is the doubled area
    function automatic longint edge_side(input int i, j, input longint px, py);
        return (vx[j] - vx[i]) * (py - vy[i]) - (vy[j] - vy[i]) * (px - vx[i]);
    endfunction

    task automatic set_triangle(input longint x0, y0, x1, y1, x2, y2);
        vx[0] = x0;
        vy[0] = y0;
        vx[1] = x1;
        vy[1] = y1;
        vx[2] = x2;
        vy[2] = y2;
        v0x_i = WORD_WIDTH'(x0);
        v0y_i = WORD_WIDTH'(y0);
        v1x_i = WORD_WIDTH'(x1);
        v1y_i = WORD_WIDTH'(y1);
        v2x_i = WORD_WIDTH'(x2);
        v2y_i = WORD_WIDTH'(y2);
    endtask

    task automatic random_ccw_triangle();
        longint rx [3];
        longint ry [3];
        int     i;
        do begin
            for (i = 0; i < 3; i++) begin
                rx[i] = $urandom_range(WIDTH * (1 << FRAC_BITS) - 1, 0);
                ry[i] = $urandom_range(HEIGHT * (1 << FRAC_BITS) - 1, 0);
            end
            set_triangle(rx[0], ry[0], rx[1], ry[1], rx[2], ry[2]);
        end while (edge_side(0, 1, vx[2], vy[2]) == 0);
        if (edge_side(0, 1, vx[2], vy[2]) < 0) begin
            set_triangle(rx[0], ry[0], rx[2], ry[2], rx[1], ry[1]);   // Flip the winding
        end
    endtask

    // Reference rasterizer over the clipped bounding box
    task automatic ref_raster(output bit discard, output int kept);
        longint lx, hx, ly, hy, x, y;
        int     a;
        kept = 0;
        for (a = 0; a < NPIX; a++) exp_keep[a] = 1'b0;
        lx = lo3(vx[0], vx[1], vx[2]) >>> FRAC_BITS;
        hx = hi3(vx[0], vx[1], vx[2]) >>> FRAC_BITS;
        ly = lo3(vy[0], vy[1], vy[2]) >>> FRAC_BITS;
        hy = hi3(vy[0], vy[1], vy[2]) >>> FRAC_BITS;
        discard = edge_side(0, 1, vx[2], vy[2]) <= 0 || hx < 0 || hy < 0 ||
                  lx >= WIDTH || ly >= HEIGHT;
        if (!discard) begin
            lx = (lx < 0) ? 0 : lx;
            ly = (ly < 0) ? 0 : ly;
            hx = (hx > WIDTH - 1) ? WIDTH - 1 : hx;
            hy = (hy > HEIGHT - 1) ? HEIGHT - 1 : hy;
            for (y = ly; y <= hy; y++) begin
                for (x = lx; x <= hx; x++) begin
                    if (edge_side(0, 1, x << FRAC_BITS, y << FRAC_BITS) >= 0 &&
                        edge_side(1, 2, x << FRAC_BITS, y << FRAC_BITS) >= 0 &&
                        edge_side(2, 0, x << FRAC_BITS, y << FRAC_BITS) >= 0) begin
                        exp_keep[y * WIDTH + x] = 1'b1;
                        kept++;
                    end
                end
            end
        end
    endtask

    task automatic start_tracking();
        int a;
        for (a = 0; a < NPIX; a++) begin
            fb_before[a] = fb_mem[a];
            wr_count[a] <= 0;
        end
        total_writes <= 0;
    endtask

    task automatic issue_clear(input logic [7:0] bg);
        bg_color_i = bg;
        clear_i    = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY clear_i = 1'b0;
    endtask

    task automatic run_draw(input bit poke, output int latency);
        int d0;
        bit finished;
        d0       = done_count;
        start_i  = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY start_i = 1'b0;
        latency  = 0;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk_i);
            latency++;
            if (done_o) begin
                finished = 1'b1;
                assert (!busy_o) else flag_mismatch("busy_o still high with done_o");
            end else begin
                assert (busy_o) else flag_mismatch("busy_o fell before done_o");
                #DRIVE_DLY start_i = poke && latency == 2;   // Ignored start while busy
            end
        end
        repeat (3) @(posedge clk_i);
        #DRIVE_DLY;
        assert (done_count == d0 + 1 && !busy_o)
            else flag_mismatch($sformatf("%0d done pulses for one draw", done_count - d0));
    endtask

    task automatic draw_and_check(input logic [7:0] color, input bit poke);
        bit discard;
        int kept, latency, a;
        ref_raster(discard, kept);
        start_tracking();
        color_i = color;
        run_draw(poke, latency);
        if (discard) begin
            assert (latency == 2 && total_writes == 0)
                else flag_mismatch($sformatf("discard: done after %0d cycles, %0d writes",
                                             latency, total_writes));
        end else begin
            assert (total_writes == kept)
                else flag_mismatch($sformatf("%0d writes, expected %0d", total_writes, kept));
            for (a = 0; a < NPIX; a++) begin
                if (exp_keep[a]) begin
                    assert (wr_count[a] == 1 && fb_mem[a] == color)
                        else flag_mismatch($sformatf("pixel %0d: %0d writes, value %0h",
                                                     a, wr_count[a], fb_mem[a]));
                end else begin
                    assert (wr_count[a] == 0 && fb_mem[a] == fb_before[a])
                        else flag_mismatch($sformatf("address %0d changed outside triangle", a));
                end
            end
        end
    endtask

    initial begin
        int n, a, d0, kept;
        bit discard;
        void'($urandom(32'h921e));
        nrst_i     = 1'b0;
        start_i    = 1'b0;
        clear_i    = 1'b0;
        color_i    = 8'h00;
        bg_color_i = 8'h00;
        set_triangle(0, 0, 0, 0, 0, 0);
        repeat (16) @(posedge clk_i);
        #DRIVE_DLY nrst_i = 1'b1;
        repeat (2) @(posedge clk_i);
        #DRIVE_DLY;
        assert (!fb_we_o && !busy_o && !done_o && !clear_done_o)
            else flag_mismatch("outputs not idle after reset");

        // Plain clear of the whole screen
        start_tracking();
        issue_clear(8'h3c);
        while (clear_active) @(posedge clk_i);
        #DRIVE_DLY;
        assert (total_writes == NPIX) else flag_mismatch("clear write count wrong");
        for (a = 0; a < NPIX; a++) begin
            assert (wr_count[a] == 1 && fb_mem[a] == 8'h3c)
                else flag_mismatch($sformatf("address %0d not cleared once", a));
        end

        for (n = 0; n < 8; n++) begin
            random_ccw_triangle();
            draw_and_check(8'(8'h80 + n), 1'b0);
        end

        // Clockwise, degenerate and off-screen triangles
        random_ccw_triangle();
        set_triangle(vx[0], vy[0], vx[2], vy[2], vx[1], vy[1]);
        draw_and_check(8'hc1, 1'b0);
        set_triangle(16, 16, 64, 48, 112, 80);
        draw_and_check(8'hc2, 1'b0);
        set_triangle(-160, 16, -48, 96, -96, 160);
        draw_and_check(8'hc3, 1'b0);

        set_triangle(-320, -160, 640, -80, 80, 480);   // Past all four edges
        draw_and_check(8'he7, 1'b0);

        random_ccw_triangle();
        draw_and_check(8'h99, 1'b1);

        // Clear issued while a large triangle is being drawn
        set_triangle(0, 0, 248, 32, 48, 184);
        ref_raster(discard, kept);
        start_tracking();
        d0      = done_count;
        color_i = 8'h5a;
        start_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY start_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #DRIVE_DLY;
        issue_clear(8'h11);
        while (clear_active || done_count == d0) @(posedge clk_i);
        repeat (3) @(posedge clk_i);
        #DRIVE_DLY;
        assert (done_count == d0 + 1 && total_writes == NPIX + kept)
            else flag_mismatch($sformatf("%0d writes, expected %0d", total_writes, NPIX + kept));
        for (a = 0; a < NPIX; a++) begin
            assert (wr_count[a] == 1 + exp_keep[a])
                else flag_mismatch($sformatf("address %0d written %0d times", a, wr_count[a]));
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/raster_pkg.sv
hdl/bbox_walker.sv
hdl/edge_eval.sv
hdl/fb_writer.sv
hdl/fb_clear.sv
hdl/fb_arbiter.sv
hdl/raster_top.sv
testbench/tb_raster.sv

// ==== Bender.yml ====
package:
  name: raster

sources:
  - hdl/raster_pkg.sv
  - hdl/bbox_walker.sv
  - hdl/edge_eval.sv
  - hdl/fb_writer.sv
  - hdl/fb_clear.sv
  - hdl/fb_arbiter.sv
  - hdl/raster_top.sv
  - target: test
    files:
      - testbench/tb_raster.sv
